//--- verilog/LaOpcodePkg.sv
package LaOpcodePkg;

    localparam int InstWidth = 32;

    // Kept LA32R instructions, in encoding order
    typedef enum logic [5:0] {
        OpAddW, OpSubW, OpSlt, OpSltu, OpNor, OpAnd, OpOr, OpXor,
        OpSllW, OpSrlW, OpSraW,
        OpMulW, OpMulhW, OpMulhWu, OpDivW, OpModW, OpDivWu, OpModWu,
        OpBreak, OpSyscall,
        OpSlliW, OpSrliW, OpSraiW,
        OpSlti, OpSltui, OpAddiW, OpAndi, OpOri, OpXori,
        OpLu12iW, OpPcaddu12i,
        OpLdB, OpLdH, OpLdW, OpStB, OpStH, OpStW, OpLdBu, OpLdHu,
        OpJirl, OpB, OpBl, OpBeq, OpBne, OpBlt, OpBge, OpBltu, OpBgeu,
        OpInvalid
    } Opcode;

    localparam int NumMatchOps = int'(OpInvalid);

    // Fixed opcode bits per instruction format
    localparam logic [InstWidth-1:0] MaskR3  = 32'hFFFF_8000;
    localparam logic [InstWidth-1:0] MaskI12 = 32'hFFC0_0000;
    localparam logic [InstWidth-1:0] MaskI20 = 32'hFE00_0000;
    localparam logic [InstWidth-1:0] MaskI26 = 32'hFC00_0000;

    typedef struct packed {
        logic [InstWidth-1:0] match;
        logic [InstWidth-1:0] mask;
    } OpEncoding;

    // Indexed by Opcode
    localparam OpEncoding OpTable [NumMatchOps] = '{
        '{32'h0010_0000, MaskR3},
        '{32'h0011_0000, MaskR3},
        '{32'h0012_0000, MaskR3},
        '{32'h0012_8000, MaskR3},
        '{32'h0014_0000, MaskR3},
        '{32'h0014_8000, MaskR3},
        '{32'h0015_0000, MaskR3},
        '{32'h0015_8000, MaskR3},
        '{32'h0017_0000, MaskR3},
        '{32'h0017_8000, MaskR3},
        '{32'h0018_0000, MaskR3},
        '{32'h001C_0000, MaskR3},
        '{32'h001C_8000, MaskR3},
        '{32'h001D_0000, MaskR3},
        '{32'h0020_0000, MaskR3},
        '{32'h0020_8000, MaskR3},
        '{32'h0021_0000, MaskR3},
        '{32'h0021_8000, MaskR3},
        '{32'h002A_0000, MaskR3},
        '{32'h002B_0000, MaskR3},
        '{32'h0040_8000, MaskR3},
        '{32'h0044_8000, MaskR3},
        '{32'h0048_8000, MaskR3},
        '{32'h0200_0000, MaskI12},
        '{32'h0240_0000, MaskI12},
        '{32'h0280_0000, MaskI12},
        '{32'h0340_0000, MaskI12},
        '{32'h0380_0000, MaskI12},
        '{32'h03C0_0000, MaskI12},
        '{32'h1400_0000, MaskI20},
        '{32'h1C00_0000, MaskI20},
        '{32'h2800_0000, MaskI12},
        '{32'h2840_0000, MaskI12},
        '{32'h2880_0000, MaskI12},
        '{32'h2900_0000, MaskI12},
        '{32'h2940_0000, MaskI12},
        '{32'h2980_0000, MaskI12},
        '{32'h2A00_0000, MaskI12},
        '{32'h2A40_0000, MaskI12},
        '{32'h4C00_0000, MaskI26},
        '{32'h5000_0000, MaskI26},
        '{32'h5400_0000, MaskI26},
        '{32'h5800_0000, MaskI26},
        '{32'h5C00_0000, MaskI26},
        '{32'h6000_0000, MaskI26},
        '{32'h6400_0000, MaskI26},
        '{32'h6800_0000, MaskI26},
        '{32'h6C00_0000, MaskI26}
    };

    // Instruction fields, lsb and width
    localparam int RdLsb     = 0;
    localparam int RjLsb     = 5;
    localparam int RkLsb     = 10;
    localparam int Ui5Lsb    = 10;
    localparam int Ui5Width  = 5;
    localparam int Si12Lsb   = 10;
    localparam int Si12Width = 12;
    localparam int Si16Lsb   = 10;
    localparam int Si16Width = 16;
    localparam int Si20Lsb   = 5;
    localparam int Si20Width = 20;

endpackage

//--- verilog/UopPkg.sv
package UopPkg;

    localparam int RegIdxWidth = 5;
    localparam int DataWidth   = 32;

    typedef enum logic [2:0] {
        UnitNone,
        UnitAlu,
        UnitMdu,
        UnitLsu,
        UnitBru,
        UnitJirl,
        UnitDir
    } UnitType;

    // Meaning depends on the unit type
    typedef logic [3:0] ConfCode;

    typedef enum logic [3:0] {
        ConfAdd, ConfSub, ConfSlt, ConfSltu, ConfNor, ConfAnd,
        ConfOr, ConfXor, ConfSll, ConfSrl, ConfSra
    } AluConf;

    typedef enum logic [3:0] {
        ConfMul, ConfMulh, ConfMulhu, ConfDiv, ConfDivu, ConfMod, ConfModu
    } MduConf;

    typedef enum logic [3:0] {
        ConfLdB, ConfLdH, ConfLdW, ConfStB, ConfStH, ConfStW, ConfLdBu, ConfLdHu
    } LsuConf;

    typedef enum logic [3:0] {
        ConfBeq, ConfBne, ConfBlt, ConfBge, ConfBltu, ConfBgeu, ConfJirl
    } BruConf;

    // Values follow the ECODE field of ESTAT
    typedef enum logic [4:0] {
        ExcpNone = 5'h00,
        ExcpSys  = 5'h0B,
        ExcpBrk  = 5'h0C,
        ExcpIne  = 5'h0D
    } ExcpCode;

endpackage

//--- verilog/DecodeStage.sv
`timescale 1ns/1ps

module DecodeStage (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                instValid,
    output logic                                instReady,
    input  logic [UopPkg::DataWidth-1:0]        pc,
    input  logic [LaOpcodePkg::InstWidth-1:0]   inst,
    output logic                                decValid,
    input  logic                                decReady,
    output LaOpcodePkg::Opcode                  decOpcode,
    output logic [UopPkg::DataWidth-1:0]        decPc,
    output logic [LaOpcodePkg::InstWidth-1:0]   decInst
);
    import LaOpcodePkg::*;

    Opcode matchOp;
    logic  accept;

    // Encodings do not overlap, so at most one entry hits
    always_comb begin
        matchOp = OpInvalid;
        for (int i = 0; i < NumMatchOps; i++) begin
            if ((inst & OpTable[i].mask) == OpTable[i].match) begin
                matchOp = Opcode'(6'(i));
            end
        end
    end

    // Free slot or one leaving this cycle
    assign instReady = !decValid || decReady;
    assign accept    = instValid && instReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid <= 1'b0;
        end else if (instReady) begin
            decValid <= instValid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            decOpcode <= matchOp;
            decPc     <= pc;
            decInst   <= inst;
        end
    end

endmodule

//--- verilog/UopQueue.sv
`timescale 1ns/1ps

module UopQueue #(
    parameter int QueueDepth = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                decValid,
    output logic                                decReady,
    input  LaOpcodePkg::Opcode                  decOpcode,
    input  logic [UopPkg::DataWidth-1:0]        decPc,
    input  logic [LaOpcodePkg::InstWidth-1:0]   decInst,
    output logic                                qValid,
    input  logic                                qReady,
    output LaOpcodePkg::Opcode                  qOpcode,
    output logic [UopPkg::DataWidth-1:0]        qPc,
    output logic [LaOpcodePkg::InstWidth-1:0]   qInst
);
    import LaOpcodePkg::*;
    import UopPkg::*;

    localparam int IdxWidth = $clog2(QueueDepth);

    Opcode                opMem   [QueueDepth];
    logic [DataWidth-1:0] pcMem   [QueueDepth];
    logic [InstWidth-1:0] instMem [QueueDepth];

    // Extra msb tells full from empty
    logic [IdxWidth:0] wrPtr;
    logic [IdxWidth:0] rdPtr;
    logic              full;
    logic              wrEn;
    logic              rdEn;

    assign full = (wrPtr[IdxWidth] != rdPtr[IdxWidth])
               && (wrPtr[IdxWidth-1:0] == rdPtr[IdxWidth-1:0]);

    assign qValid   = wrPtr != rdPtr;
    // A full queue still takes a write when the head leaves
    assign decReady = !full || qReady;
    assign wrEn     = decValid && decReady;
    assign rdEn     = qValid && qReady;

    assign qOpcode = opMem[rdPtr[IdxWidth-1:0]];
    assign qPc     = pcMem[rdPtr[IdxWidth-1:0]];
    assign qInst   = instMem[rdPtr[IdxWidth-1:0]];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            opMem[wrPtr[IdxWidth-1:0]]   <= decOpcode;
            pcMem[wrPtr[IdxWidth-1:0]]   <= decPc;
            instMem[wrPtr[IdxWidth-1:0]] <= decInst;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (wrEn) wrPtr <= wrPtr + (IdxWidth + 1)'(1);
            if (rdEn) rdPtr <= rdPtr + (IdxWidth + 1)'(1);
        end
    end

endmodule

//--- verilog/UopBuilder.sv
`timescale 1ns/1ps

module UopBuilder (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                qValid,
    output logic                                qReady,
    input  LaOpcodePkg::Opcode                  qOpcode,
    input  logic [UopPkg::DataWidth-1:0]        qPc,
    input  logic [LaOpcodePkg::InstWidth-1:0]   qInst,
    output logic                                uopValid,
    input  logic                                uopReady,
    output logic [UopPkg::RegIdxWidth-1:0]      rj,
    output logic [UopPkg::RegIdxWidth-1:0]      rk,
    output logic [UopPkg::RegIdxWidth-1:0]      rd,
    output logic [UopPkg::DataWidth-1:0]        imm,
    output UopPkg::UnitType                     unitType,
    output UopPkg::ConfCode                     conf,
    output logic                                isImm,
    output logic                                regWr,
    output logic                                isStore,
    output UopPkg::ExcpCode                     excpCode,
    output logic                                hasExcp
);
    import LaOpcodePkg::*;
    import UopPkg::*;

    // Operand layout of an instruction
    typedef enum logic [3:0] {
        FmtNone, FmtReg, FmtSi12, FmtUi12, FmtUi5, FmtLoad, FmtStore, FmtBranch,
        FmtJirl, FmtBl, FmtLu12i, FmtPcAdd, FmtBreak, FmtSyscall, FmtIllegal
    } OperandFmt;

    typedef struct packed {
        UnitType   unit;
        ConfCode   conf;
        OperandFmt fmt;
    } UopAttr;

    UopAttr                      attr;
    logic signed [Si12Width-1:0] si12;
    logic signed [Si16Width-1:0] si16;
    logic [DataWidth-1:0]        upperImm;
    logic [DataWidth-1:0]        nImm;
    ExcpCode                     nExcp;
    logic                        useRj;
    logic                        useRd;
    logic                        take;

    always_comb begin
        case (qOpcode)
            OpAddW:      attr = '{UnitAlu, ConfAdd, FmtReg};
            OpSubW:      attr = '{UnitAlu, ConfSub, FmtReg};
            OpSlt:       attr = '{UnitAlu, ConfSlt, FmtReg};
            OpSltu:      attr = '{UnitAlu, ConfSltu, FmtReg};
            OpNor:       attr = '{UnitAlu, ConfNor, FmtReg};
            OpAnd:       attr = '{UnitAlu, ConfAnd, FmtReg};
            OpOr:        attr = '{UnitAlu, ConfOr, FmtReg};
            OpXor:       attr = '{UnitAlu, ConfXor, FmtReg};
            OpSllW:      attr = '{UnitAlu, ConfSll, FmtReg};
            OpSrlW:      attr = '{UnitAlu, ConfSrl, FmtReg};
            OpSraW:      attr = '{UnitAlu, ConfSra, FmtReg};
            OpMulW:      attr = '{UnitMdu, ConfMul, FmtReg};
            OpMulhW:     attr = '{UnitMdu, ConfMulh, FmtReg};
            OpMulhWu:    attr = '{UnitMdu, ConfMulhu, FmtReg};
            OpDivW:      attr = '{UnitMdu, ConfDiv, FmtReg};
            OpModW:      attr = '{UnitMdu, ConfMod, FmtReg};
            OpDivWu:     attr = '{UnitMdu, ConfDivu, FmtReg};
            OpModWu:     attr = '{UnitMdu, ConfModu, FmtReg};
            OpBreak:     attr = '{UnitNone, '0, FmtBreak};
            OpSyscall:   attr = '{UnitNone, '0, FmtSyscall};
            OpSlliW:     attr = '{UnitAlu, ConfSll, FmtUi5};
            OpSrliW:     attr = '{UnitAlu, ConfSrl, FmtUi5};
            OpSraiW:     attr = '{UnitAlu, ConfSra, FmtUi5};
            OpSlti:      attr = '{UnitAlu, ConfSlt, FmtSi12};
            OpSltui:     attr = '{UnitAlu, ConfSltu, FmtSi12};
            OpAddiW:     attr = '{UnitAlu, ConfAdd, FmtSi12};
            OpAndi:      attr = '{UnitAlu, ConfAnd, FmtUi12};
            OpOri:       attr = '{UnitAlu, ConfOr, FmtUi12};
            OpXori:      attr = '{UnitAlu, ConfXor, FmtUi12};
            OpLu12iW:    attr = '{UnitDir, '0, FmtLu12i};
            OpPcaddu12i: attr = '{UnitDir, '0, FmtPcAdd};
            OpLdB:       attr = '{UnitLsu, ConfLdB, FmtLoad};
            OpLdH:       attr = '{UnitLsu, ConfLdH, FmtLoad};
            OpLdW:       attr = '{UnitLsu, ConfLdW, FmtLoad};
            OpStB:       attr = '{UnitLsu, ConfStB, FmtStore};
            OpStH:       attr = '{UnitLsu, ConfStH, FmtStore};
            OpStW:       attr = '{UnitLsu, ConfStW, FmtStore};
            OpLdBu:      attr = '{UnitLsu, ConfLdBu, FmtLoad};
            OpLdHu:      attr = '{UnitLsu, ConfLdHu, FmtLoad};
            OpJirl:      attr = '{UnitJirl, ConfJirl, FmtJirl};
            // Plain B needs nothing past fetch
            OpB:         attr = '{UnitNone, '0, FmtNone};
            OpBl:        attr = '{UnitDir, '0, FmtBl};
            OpBeq:       attr = '{UnitBru, ConfBeq, FmtBranch};
            OpBne:       attr = '{UnitBru, ConfBne, FmtBranch};
            OpBlt:       attr = '{UnitBru, ConfBlt, FmtBranch};
            OpBge:       attr = '{UnitBru, ConfBge, FmtBranch};
            OpBltu:      attr = '{UnitBru, ConfBltu, FmtBranch};
            OpBgeu:      attr = '{UnitBru, ConfBgeu, FmtBranch};
            default:     attr = '{UnitNone, '0, FmtIllegal};
        endcase
    end

    assign si12     = qInst[Si12Lsb +: Si12Width];
    assign si16     = qInst[Si16Lsb +: Si16Width];
    assign upperImm = {qInst[Si20Lsb +: Si20Width], {(DataWidth - Si20Width){1'b0}}};

    always_comb begin
        case (attr.fmt)
            FmtSi12, FmtLoad, FmtStore: nImm = DataWidth'(si12);
            FmtUi12:  nImm = DataWidth'(qInst[Si12Lsb +: Si12Width]);
            FmtUi5:   nImm = DataWidth'(qInst[Ui5Lsb +: Ui5Width]);
            FmtJirl:  nImm = DataWidth'(si16) << 2;
            FmtBl:    nImm = qPc + DataWidth'(4);
            FmtLu12i: nImm = upperImm;
            FmtPcAdd: nImm = qPc + upperImm;
            default:  nImm = '0;
        endcase
    end

    assign useRj = attr.fmt inside {FmtReg, FmtSi12, FmtUi12, FmtUi5, FmtLoad, FmtStore,
                                    FmtBranch, FmtJirl};
    assign useRd = useRj || attr.fmt inside {FmtLu12i, FmtPcAdd};

    assign nExcp = (attr.fmt == FmtBreak)   ? ExcpBrk :
                   (attr.fmt == FmtSyscall) ? ExcpSys :
                   (attr.fmt == FmtIllegal) ? ExcpIne : ExcpNone;

    assign qReady  = !uopValid || uopReady;
    assign take    = qValid && qReady;
    assign hasExcp = excpCode != ExcpNone;

    always_ff @(posedge clk) begin
        if (rst) begin
            uopValid <= 1'b0;
        end else if (qReady) begin
            uopValid <= qValid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rj       <= useRj ? qInst[RjLsb +: RegIdxWidth] : '0;
            rk       <= (attr.fmt == FmtReg) ? qInst[RkLsb +: RegIdxWidth] : '0;
            // BL links through r1
            rd       <= (attr.fmt == FmtBl) ? RegIdxWidth'(1) :
                        useRd ? qInst[RdLsb +: RegIdxWidth] : '0;
            imm      <= nImm;
            unitType <= attr.unit;
            conf     <= attr.conf;
            isImm    <= attr.fmt inside {FmtSi12, FmtUi12, FmtUi5};
            regWr    <= attr.fmt inside {FmtReg, FmtSi12, FmtUi12, FmtUi5, FmtLoad, FmtJirl,
                                         FmtBl, FmtLu12i, FmtPcAdd};
            isStore  <= attr.fmt == FmtStore;
            excpCode <= nExcp;
        end
    end

endmodule

//--- verilog/DecoderTop.sv
`timescale 1ns/1ps

module DecoderTop #(
    parameter int QueueDepth = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                instValid,
    output logic                                instReady,
    input  logic [UopPkg::DataWidth-1:0]        pc,
    input  logic [LaOpcodePkg::InstWidth-1:0]   inst,
    output logic                                uopValid,
    input  logic                                uopReady,
    output logic [UopPkg::RegIdxWidth-1:0]      rj,
    output logic [UopPkg::RegIdxWidth-1:0]      rk,
    output logic [UopPkg::RegIdxWidth-1:0]      rd,
    output logic [UopPkg::DataWidth-1:0]        imm,
    output UopPkg::UnitType                     unitType,
    output UopPkg::ConfCode                     conf,
    output logic                                isImm,
    output logic                                regWr,
    output logic                                isStore,
    output UopPkg::ExcpCode                     excpCode,
    output logic                                hasExcp
);
    import LaOpcodePkg::*;
    import UopPkg::*;

    // Decode stage to queue
    logic                 decValid;
    logic                 decReady;
    Opcode                decOpcode;
    logic [DataWidth-1:0] decPc;
    logic [InstWidth-1:0] decInst;

    // Queue head to builder
    logic                 qValid;
    logic                 qReady;
    Opcode                qOpcode;
    logic [DataWidth-1:0] qPc;
    logic [InstWidth-1:0] qInst;

    DecodeStage i_DecodeStage (.*);

    UopQueue #(
        .QueueDepth(QueueDepth)
    ) i_UopQueue (.*);

    UopBuilder i_UopBuilder (.*);

endmodule

//--- test/DecoderProps_props.sv
`timescale 1ns/1ps

module DecoderProps (
    input logic        clk,
    input logic        rst,
    input logic        instReady,
    input logic        uopValid,
    input logic        uopReady,
    input logic [4:0]  rj,
    input logic [4:0]  rk,
    input logic [4:0]  rd,
    input logic [31:0] imm,
    input logic [2:0]  unitType,
    input logic [3:0]  conf,
    input logic        isImm,
    input logic        regWr,
    input logic        isStore,
    input logic [4:0]  excpCode,
    input logic        hasExcp
);
    logic [62:0] fields;

    assign fields = {rj, rk, rd, imm, unitType, conf, isImm, regWr, isStore, excpCode, hasExcp};

    // Held output must not move until it is taken
    assert property (@(posedge clk) disable iff (rst)
        uopValid && !uopReady |=> uopValid && $stable(fields))
        else $error("output changed while stalled");

    assert property (@(posedge clk) $past(rst) |-> !uopValid && instReady)
        else $error("handshake not idle after reset");

    assert property (@(posedge clk) disable iff (rst) uopValid |-> !$isunknown(fields))
        else $error("unknown output field while valid");

endmodule

bind DecoderTop DecoderProps i_DecoderProps (.*);

//--- test/DecoderTb.sv
`timescale 1ns/1ps

module DecoderTb;

    localparam int MaxVecs  = 64;
    localparam int Timeout  = 1000;
    localparam int StallAt  = 10;
    localparam int NumCols  = 13;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        instValid = 1'b0;
    logic        instReady;
    logic [31:0] pc = '0;
    logic [31:0] inst = '0;
    logic        uopValid;
    logic        uopReady = 1'b0;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic [2:0]  unitType;
    logic [3:0]  conf;
    logic        isImm;
    logic        regWr;
    logic        isStore;
    logic [4:0]  excpCode;
    logic        hasExcp;

    string       names [MaxVecs];
    logic [31:0] vecs [MaxVecs][NumCols];
    int          numVecs = 0;
    integer      seed = 61;

    DecoderTop i_DecoderTop (
        .clk(clk), .rst(rst), .instValid(instValid), .instReady(instReady), .pc(pc),
        .inst(inst), .uopValid(uopValid), .uopReady(uopReady), .rj(rj), .rk(rk), .rd(rd),
        .imm(imm), .unitType(unitType), .conf(conf), .isImm(isImm), .regWr(regWr),
        .isStore(isStore), .excpCode(excpCode), .hasExcp(hasExcp)
    );

    always #20 clk = ~clk;

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic loadVectors();
        integer      fd;
        string       line;
        string       name;
        logic [31:0] f [NumCols];
        int          cnt;
        fd = $fopen("test/decoder_testdata.txt", "r");
        assert (fd != 0) else failRun("cannot open test/decoder_testdata.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;
            cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                          f[10], f[11], f[12]);
            assert (cnt == NumCols + 1) else failRun({"bad vector line: ", line});
            names[numVecs] = name;
            for (int c = 0; c < NumCols; c++) vecs[numVecs][c] = f[c];
            numVecs++;
        end
        $fclose(fd);
    endtask

    task automatic checkField(input string vec, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
        assert (expected === actual) else
            failRun($sformatf("mismatch %s %s expected %h actual %h",
                              vec, field, expected, actual));
    endtask

    task automatic checkRecord(input int i);
        checkField(names[i], "rj", vecs[i][2], 32'(rj));
        checkField(names[i], "rk", vecs[i][3], 32'(rk));
        checkField(names[i], "rd", vecs[i][4], 32'(rd));
        checkField(names[i], "imm", vecs[i][5], imm);
        checkField(names[i], "unitType", vecs[i][6], 32'(unitType));
        checkField(names[i], "conf", vecs[i][7], 32'(conf));
        checkField(names[i], "isImm", vecs[i][8], 32'(isImm));
        checkField(names[i], "regWr", vecs[i][9], 32'(regWr));
        checkField(names[i], "isStore", vecs[i][10], 32'(isStore));
        checkField(names[i], "excpCode", vecs[i][11], 32'(excpCode));
        checkField(names[i], "hasExcp", vecs[i][12], 32'(hasExcp));
    endtask

    // Called on a rising edge, returns on the edge of the transfer
    task automatic sendItem(input int i);
        int   waited;
        logic ready;
        waited = 0;
        instValid <= 1'b1;
        pc        <= vecs[i][0];
        inst      <= vecs[i][1];
        do begin
            @(negedge clk);
            ready = instReady;
            waited++;
            assert (waited < Timeout) else failRun($sformatf("input stalled at %s", names[i]));
            @(posedge clk);
        end while (!ready);
    endtask

    // Output blocked long enough to back up the whole pipeline
    task automatic holdOutput();
        logic sawFull;
        sawFull = 1'b0;
        uopReady <= 1'b0;
        repeat (20) begin
            @(negedge clk);
            if (!instReady) sawFull = 1'b1;
            @(posedge clk);
        end
        assert (sawFull) else failRun("instReady never dropped while the output was held");
    endtask

    task automatic driveInputs();
        for (int i = 0; i < numVecs; i++) begin
            while ({$random(seed)} % 4 == 0) begin
                instValid <= 1'b0;
                @(posedge clk);
            end
            sendItem(i);
        end
        instValid <= 1'b0;
    endtask

    task automatic collectOutputs();
        int   got;
        int   idle;
        int   recoverWait;
        logic stalled;
        logic recovering;
        got = 0;
        idle = 0;
        recoverWait = 0;
        stalled = 1'b0;
        recovering = 1'b0;
        while (got < numVecs) begin
            if (got == StallAt && !stalled) begin
                holdOutput();
                stalled = 1'b1;
                recovering = 1'b1;
                uopReady <= 1'b1;
            end else begin
                uopReady <= ({$random(seed)} % 4) != 0;
            end
            @(negedge clk);
            if (recovering) begin
                if (instReady) recovering = 1'b0;
                recoverWait++;
                assert (recoverWait < Timeout) else
                    failRun("instReady did not recover after the stall");
            end
            if (uopValid && uopReady) begin
                checkRecord(got);
                got++;
                idle = 0;
            end else begin
                idle++;
                assert (idle < Timeout) else
                    failRun($sformatf("no output for %s", names[got]));
            end
            @(posedge clk);
        end
    endtask

    initial begin
        loadVectors();
        assert (numVecs > StallAt) else failRun("too few test vectors");
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        fork
            driveInputs();
            collectOutputs();
        join
        $display("Regression passed");
        $finish;
    end

endmodule

//--- build.f
verilog/LaOpcodePkg.sv
verilog/UopPkg.sv
verilog/DecodeStage.sv
verilog/UopQueue.sv
verilog/UopBuilder.sv
verilog/DecoderTop.sv
test/DecoderProps_props.sv
test/DecoderTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wall -Wno-fatal -f build.f \
    --top-module DecoderTb -o DecoderSim
./obj_dir/DecoderSim | tee sim.log

if grep -q "Regression passed" sim.log; then
    exit 0
else
    exit 1
fi

//--- test/decoder_testdata.txt
# name pc inst | expected rj rk rd imm unitType conf isImm regWr isStore excpCode hasExcp
# all values hex
add_w      1c000000 00101483 04 05 03 00000000 1 0 0 1 0 00 0
sltu       1c000004 00129483 04 05 03 00000000 1 3 0 1 0 00 0
nor        1c000008 00141483 04 05 03 00000000 1 4 0 1 0 00 0
xor        1c00000c 00159483 04 05 03 00000000 1 7 0 1 0 00 0
sra_w      1c000010 00181483 04 05 03 00000000 1 a 0 1 0 00 0
mul_w      1c000014 001c1483 04 05 03 00000000 2 0 0 1 0 00 0
div_w      1c000018 00201483 04 05 03 00000000 2 3 0 1 0 00 0
mod_w      1c00001c 00209483 04 05 03 00000000 2 5 0 1 0 00 0
mod_wu     1c000020 00219483 04 05 03 00000000 2 6 0 1 0 00 0
slli_w     1c000024 00409c83 04 00 03 00000007 1 8 1 1 0 00 0
srli_w     1c000028 0044fc83 04 00 03 0000001f 1 9 1 1 0 00 0
addi_neg   1c00002c 02bffc83 04 00 03 ffffffff 1 0 1 1 0 00 0
addi_pos   1c000030 029ffc83 04 00 03 000007ff 1 0 1 1 0 00 0
slti       1c000034 02200083 04 00 03 fffff800 1 2 1 1 0 00 0
andi       1c000038 037ffc83 04 00 03 00000fff 1 5 1 1 0 00 0
ori        1c00003c 03a00083 04 00 03 00000800 1 6 1 1 0 00 0
xori       1c000040 03c29483 04 00 03 000000a5 1 7 1 1 0 00 0
ld_b       1c000044 283ff083 04 00 03 fffffffc 3 0 0 1 0 00 0
ld_w       1c000048 289ffc83 04 00 03 000007ff 3 2 0 1 0 00 0
st_b       1c00004c 29200083 04 00 03 fffff800 3 3 0 0 1 00 0
st_h       1c000050 29400883 04 00 03 00000002 3 4 0 0 1 00 0
st_w       1c000054 29bfc083 04 00 03 fffffff0 3 5 0 0 1 00 0
beq        1c000058 5848d083 04 00 03 00000000 4 0 0 0 0 00 0
bne        1c00005c 5c48d083 04 00 03 00000000 4 1 0 0 0 00 0
bltu       1c000060 6848d083 04 00 03 00000000 4 4 0 0 0 00 0
bgeu       1c000064 6c48d083 04 00 03 00000000 4 5 0 0 0 00 0
jirl_neg   1c000068 4ffffc83 04 00 03 fffffffc 5 6 0 1 0 00 0
jirl_pos   1c00006c 4c004083 04 00 03 00000040 5 6 0 1 0 00 0
b          1c000070 50123456 00 00 00 00000000 0 0 0 0 0 00 0
bl_low     1c000074 54abcdef 00 00 01 1c000078 6 0 0 1 0 00 0
bl_wrap    fffffffc 54abcdef 00 00 01 00000000 6 0 0 1 0 00 0
lu12i_w    1c000080 15579bc3 00 00 03 abcde000 6 0 0 1 0 00 0
pcaddu_pos 1c000010 1c000023 00 00 03 1c001010 6 0 0 1 0 00 0
pcaddu_neg 00002000 1dffffe3 00 00 03 00001000 6 0 0 1 0 00 0
break      1c000090 002a0005 00 00 00 00000000 0 0 0 0 0 0c 1
syscall    1c000094 002b0011 00 00 00 00000000 0 0 0 0 0 0b 1
csrrd      1c000098 04000c03 00 00 00 00000000 0 0 0 0 0 0d 1
invalid    1c00009c ffffffff 00 00 00 00000000 0 0 0 0 0 0d 1
